//--- filelist.f
source/rv_isa_pkg.sv
source/core_types_pkg.sv
source/idu_exu_if.sv
source/fetch_unit.sv
source/decode_unit.sv
source/regfile.sv
source/execute_unit.sv
source/rv_core_top.sv
test/core_asserts.sv
test/tb_core.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_core
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?= +verilator+error+limit+100

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Simulation failed" $(LOG); then echo "run failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "Simulation passed" $(LOG); then echo "run ended early, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- test/tb_core.sv
`timescale 1ns/1ns
`default_nettype none

module tb_core
    import core_types_pkg::*;
    import rv_isa_pkg::*;
();

    localparam int CLK_PERIOD      = 20;
    localparam int RESET_CYCLES    = 16;
    localparam int RUN_BUDGET      = 400;
    localparam int TAIL_CYCLES     = 8;
    localparam int NUM_RUNS        = 7;
    localparam int WATCHDOG_CYCLES = NUM_RUNS * (RESET_CYCLES + RUN_BUDGET + TAIL_CYCLES + 30);

    logic  clk        = 1'b0;
    logic  rst        = 1'b1;
    logic  imem_req;
    addr_t imem_addr;
    inst_t imem_rdata = '0;
    logic  imem_ack   = 1'b0;
    logic  dmem_req;
    addr_t dmem_addr;
    word_t dmem_wdata;
    logic  dmem_ack   = 1'b0;
    logic  halted;

    inst_t       imem [256];
    int          load_idx = 0;
    word_t       exp_addr[$];
    word_t       exp_data[$];
    word_t       got_addr[$];
    word_t       got_data[$];
    logic [31:0] rng       = 32'he3b8_0e82;
    logic        rand_acks = 1'b0;
    int          imem_wait = 0;
    int          dmem_wait = 0;
    int          errors      = 0;
    int          checks      = 0;
    int          tests_run   = 0;
    int          test_errors = 0;

    always #(CLK_PERIOD / 2) clk = ~clk;

    rv_core_top dut0 (
        .clk_i        (clk),
        .rst_i        (rst),
        .imem_req_o   (imem_req),
        .imem_addr_o  (imem_addr),
        .imem_rdata_i (imem_rdata),
        .imem_ack_i   (imem_ack),
        .dmem_req_o   (dmem_req),
        .dmem_addr_o  (dmem_addr),
        .dmem_wdata_o (dmem_wdata),
        .dmem_ack_i   (dmem_ack),
        .halted_o     (halted)
    );

    function automatic logic [31:0] xorshift32();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic int next_delay();
        logic [31:0] r;
        if (!rand_acks) begin
            return 0;
        end
        r = xorshift32();
        return int'(r[1:0]);
    endfunction

    // instruction memory, four-phase responder.
    always @(posedge clk) begin
        if (rst) begin
            imem_ack  <= 1'b0;
            imem_wait <= 0;
        end else if (imem_req && !imem_ack) begin
            if (imem_wait == 0) begin
                imem_ack   <= 1'b1;
                imem_rdata <= imem[imem_addr[9:2]];
                imem_wait  <= next_delay();
            end else begin
                imem_wait <= imem_wait - 1;
            end
        end else if (!imem_req && imem_ack) begin
            imem_ack <= 1'b0;
        end
    end

    // data memory only records the stores it accepts.
    always @(posedge clk) begin
        if (rst) begin
            dmem_ack  <= 1'b0;
            dmem_wait <= 0;
        end else if (dmem_req && !dmem_ack) begin
            if (dmem_wait == 0) begin
                dmem_ack <= 1'b1;
                got_addr.push_back(dmem_addr);
                got_data.push_back(dmem_wdata);
                dmem_wait <= next_delay();
            end else begin
                dmem_wait <= dmem_wait - 1;
            end
        end else if (!dmem_req && dmem_ack) begin
            dmem_ack <= 1'b0;
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles", WATCHDOG_CYCLES);
        $display("Simulation failed");
        $finish;
    end

    function automatic inst_t enc_addi(input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], F3_ADDI, rd[4:0], OPC_OP_IMM};
    endfunction

    function automatic inst_t enc_sw(input int rs2, input int rs1, input int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], F3_SW, imm[4:0], OPC_STORE};
    endfunction

    function automatic inst_t enc_u(input opcode_t opc, input int rd, input int imm20);
        return {imm20[19:0], rd[4:0], opc};
    endfunction

    function automatic inst_t enc_jal(input int rd, input int off);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], OPC_JAL};
    endfunction

    function automatic inst_t enc_jalr(input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], OPC_JALR};
    endfunction

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            $display("** Error: %s expected %h actual %h", name, exp, act);
            errors++;
            test_errors++;
        end
    endtask

    // unused words become addi x0, x0, index.
    task automatic clear_prog();
        for (int i = 0; i < 256; i++) begin
            imem[i] = enc_addi(0, 0, i);
        end
        load_idx = 0;
        exp_addr.delete();
        exp_data.delete();
    endtask

    task automatic put(input inst_t w);
        imem[load_idx] = w;
        load_idx++;
    endtask

    task automatic expect_store(input word_t addr, input word_t data);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
    endtask

    task automatic reset_core();
        @(posedge clk);
        rst <= 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        got_addr.delete();
        got_data.delete();
        rst <= 1'b0;
    endtask

    task automatic wait_halt(input string name);
        int cycles;
        cycles = 0;
        while (!halted && cycles < RUN_BUDGET) begin
            @(posedge clk);
            cycles++;
        end
        if (!halted) begin
            $display("%s: core did not halt within %0d cycles", name, RUN_BUDGET);
            errors++;
            test_errors++;
        end
        repeat (TAIL_CYCLES) @(posedge clk);
    endtask

    task automatic check_stores(input string name);
        int n;
        n = exp_addr.size();
        if (got_addr.size() != n) begin
            $display("%s: expected %0d stores but the core made %0d", name, n, got_addr.size());
            errors++;
            test_errors++;
            if (got_addr.size() < n) begin
                n = got_addr.size();
            end
        end
        for (int i = 0; i < n; i++) begin
            check(name, exp_addr[i], got_addr[i]);
            check(name, exp_data[i], got_data[i]);
        end
    endtask

    task automatic run_and_check(input string name);
        reset_core();
        wait_halt(name);
        check_stores(name);
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (test_errors == 0) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, test_errors);
        end
        test_errors = 0;
    endtask

    task automatic load_arith();
        int v1;
        int v2;
        int v3;
        int v4;
        clear_prog();
        put(enc_addi(1, 0, 100));
        put(enc_addi(2, 1, -300));
        put(enc_u(OPC_LUI, 3, 'h12345));
        put(enc_addi(3, 3, -1));
        put(enc_u(OPC_LUI, 4, 'hfffff));
        put(enc_addi(4, 4, -2048));
        put(enc_addi(5, 0, 'h200));
        put(enc_sw(1, 5, 0));
        put(enc_sw(2, 5, 4));
        put(enc_sw(3, 5, 8));
        put(enc_sw(4, 5, 12));
        put(INST_EBREAK);
        v1 = 100;
        v2 = v1 - 300;
        v3 = (32'h12345 << 12) - 1;
        v4 = (32'hfffff << 12) - 2048;
        expect_store('h200, v1);
        expect_store('h204, v2);
        expect_store('h208, v3);
        expect_store('h20c, v4);
    endtask

    task automatic load_jalr();
        clear_prog();
        put(enc_addi(1, 0, 17));
        // 17 + 4 is odd, the target lands on 20.
        put(enc_jalr(3, 1, 4));
        put(enc_sw(1, 0, 'h50));
        put(enc_sw(1, 0, 'h54));
        put(enc_sw(1, 0, 'h58));
        put(enc_addi(0, 0, 99));
        put(enc_sw(0, 0, 'h60));
        put(enc_sw(3, 0, 'h64));
        // this link shows whether the first jump cleared bit 0.
        put(enc_jalr(4, 1, 23));
        put(enc_sw(1, 0, 'h6c));
        put(enc_sw(4, 0, 'h68));
        put(INST_EBREAK);
        expect_store('h60, 0);
        expect_store('h64, 4 + 4);
        expect_store('h68, 32 + 4);
    endtask

    task automatic test_addi_lui();
        load_arith();
        run_and_check("addi_lui");
        end_test("addi_lui");
    endtask

    task automatic test_auipc_sw();
        int x5;
        clear_prog();
        put(enc_addi(6, 0, 'h55));
        put(enc_u(OPC_AUIPC, 5, 1));
        put(enc_sw(6, 5, -8));
        put(enc_u(OPC_AUIPC, 7, 0));
        put(enc_sw(7, 5, -4));
        put(INST_EBREAK);
        // auipc sits at pc 4.
        x5 = 4 + (1 << 12);
        expect_store(x5 - 8, 'h55);
        expect_store(x5 - 4, 12);
        run_and_check("auipc_sw");
        end_test("auipc_sw");
    endtask

    task automatic test_jal_skip();
        clear_prog();
        put(enc_addi(1, 0, 7));
        put(enc_jal(2, 12));
        put(enc_sw(1, 0, 'h00));
        put(enc_sw(1, 0, 'h04));
        put(enc_sw(2, 0, 'h40));
        put(enc_jal(0, 8));
        put(enc_sw(1, 0, 'h44));
        put(enc_sw(1, 0, 'h48));
        put(INST_EBREAK);
        expect_store('h40, 4 + 4);
        expect_store('h48, 7);
        run_and_check("jal_skip");
        end_test("jal_skip");
    endtask

    task automatic test_jalr_x0();
        load_jalr();
        run_and_check("jalr_x0");
        end_test("jalr_x0");
    endtask

    task automatic run_with_random_acks(input string name);
        rand_acks = 1'b1;
        run_and_check(name);
        rand_acks = 1'b0;
    endtask

    task automatic test_random_acks();
        load_arith();
        run_with_random_acks("random_acks");
        load_jalr();
        run_with_random_acks("random_acks");
        end_test("random_acks");
    endtask

    task automatic test_halt_reset();
        clear_prog();
        put(enc_addi(1, 0, 5));
        put(enc_sw(1, 0, 'h70));
        put(INST_EBREAK);
        expect_store('h70, 5);
        reset_core();
        check("halt_reset", 0, 32'(imem_req));
        check("halt_reset", 0, 32'(dmem_req));
        check("halt_reset", 0, 32'(halted));
        // rst falls on the next edge, the request follows one edge later.
        repeat (2) @(posedge clk);
        check("halt_reset", 1, 32'(imem_req));
        check("halt_reset", RESET_PC, imem_addr);
        wait_halt("halt_reset");
        check_stores("halt_reset");
        repeat (20) begin
            @(posedge clk);
            check("halt_reset", 0, 32'(imem_req));
            check("halt_reset", 0, 32'(dmem_req));
            check("halt_reset", 1, 32'(halted));
        end
        end_test("halt_reset");
    endtask

    initial begin
        test_addi_lui();
        test_auipc_sw();
        test_jal_skip();
        test_jalr_x0();
        test_random_acks();
        test_halt_reset();
        errors = errors + dut0.u_asserts.fail_count;
        $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- test/core_asserts.sv
`timescale 1ns/1ns
`default_nettype none

module core_asserts (
    input wire clk_i,
    input wire rst_i,
    input wire imem_req_i,
    input wire imem_ack_i,
    input wire dmem_req_i,
    input wire dmem_ack_i,
    input wire halted_i
);

    int fail_count = 0;

    // the core talks to one memory at a time.
    a_one_port: assert property (@(posedge clk_i) disable iff (rst_i)
        !(imem_req_i && dmem_req_i))
        else begin
            fail_count++;
            $error("imem and dmem requests are high in the same cycle");
        end

    a_imem_release: assert property (@(posedge clk_i) disable iff (rst_i)
        $fell(imem_req_i) |-> $past(imem_ack_i))
        else begin
            fail_count++;
            $error("imem request dropped before ack was seen");
        end

    a_dmem_release: assert property (@(posedge clk_i) disable iff (rst_i)
        $fell(dmem_req_i) |-> $past(dmem_ack_i))
        else begin
            fail_count++;
            $error("dmem request dropped before ack was seen");
        end

    // a halted core stays quiet until reset.
    a_halt_quiet: assert property (@(posedge clk_i) disable iff (rst_i)
        halted_i |-> (!imem_req_i && !dmem_req_i))
        else begin
            fail_count++;
            $error("request issued while halted");
        end

    a_halt_sticky: assert property (@(posedge clk_i) disable iff (rst_i)
        halted_i |=> halted_i)
        else begin
            fail_count++;
            $error("halt dropped without reset");
        end

endmodule

bind rv_core_top core_asserts u_asserts (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .imem_req_i (imem_req_o),
    .imem_ack_i (imem_ack_i),
    .dmem_req_i (dmem_req_o),
    .dmem_ack_i (dmem_ack_i),
    .halted_i   (halted_o)
);

`default_nettype wire

//--- source/rv_core_top.sv
`timescale 1ns/1ns
`default_nettype none

module rv_core_top
    import core_types_pkg::*;
(
    input  wire         clk_i,
    input  wire         rst_i,
    output logic        imem_req_o,
    output addr_t       imem_addr_o,
    input  wire inst_t  imem_rdata_i,
    input  wire         imem_ack_i,
    output logic        dmem_req_o,
    output addr_t       dmem_addr_o,
    output word_t       dmem_wdata_o,
    input  wire         dmem_ack_i,
    output logic        halted_o
);

    inst_t     inst;
    addr_t     pc;
    addr_t     next_pc;
    logic      commit;
    reg_addr_t raddr1;
    reg_addr_t raddr2;
    word_t     rdata1;
    word_t     rdata2;
    word_t     wb_data;

    idu_exu_if u_idu_exu ();

    fetch_unit u_fetch (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .imem_req_o   (imem_req_o),
        .imem_addr_o  (imem_addr_o),
        .imem_rdata_i (imem_rdata_i),
        .imem_ack_i   (imem_ack_i),
        .dmem_req_o   (dmem_req_o),
        .dmem_ack_i   (dmem_ack_i),
        .is_store_i   (u_idu_exu.is_store),
        .is_ebreak_i  (u_idu_exu.is_ebreak),
        .next_pc_i    (next_pc),
        .inst_o       (inst),
        .pc_o         (pc),
        .commit_o     (commit),
        .halted_o     (halted_o)
    );

    decode_unit u_decode (
        .inst_i   (inst),
        .pc_i     (pc),
        .rdata1_i (rdata1),
        .rdata2_i (rdata2),
        .raddr1_o (raddr1),
        .raddr2_o (raddr2),
        .dec      (u_idu_exu.dec)
    );

    regfile u_regfile (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .raddr1_i (raddr1),
        .raddr2_i (raddr2),
        .rdata1_o (rdata1),
        .rdata2_o (rdata2),
        .we_i     (commit && u_idu_exu.reg_wen),
        .waddr_i  (u_idu_exu.waddr),
        .wdata_i  (wb_data)
    );

    execute_unit u_execute (
        .exe          (u_idu_exu.exe),
        .rdata2_i     (rdata2),
        .pc_i         (pc),
        .wb_data_o    (wb_data),
        .next_pc_o    (next_pc),
        .store_addr_o (dmem_addr_o),
        .store_data_o (dmem_wdata_o)
    );

endmodule

`default_nettype wire

//--- source/execute_unit.sv
`timescale 1ns/1ns
`default_nettype none

module execute_unit
    import core_types_pkg::*;
    import rv_isa_pkg::*;
(
    idu_exu_if.exe      exe,
    input  wire word_t  rdata2_i,
    input  wire addr_t  pc_i,
    output word_t       wb_data_o,
    output addr_t       next_pc_o,
    output addr_t       store_addr_o,
    output word_t       store_data_o
);

    word_t sum;
    addr_t jump_target;
    addr_t seq_pc;
    logic  is_jalr;

    // one adder serves writeback and the store address.
    assign sum = exe.op1 + exe.op2;

    assign is_jalr = (get_opcode(exe.inst) == OPC_JALR);

    always_comb begin
        jump_target = exe.op1_jump + exe.op2_jump;
        if (is_jalr) begin
            jump_target[0] = 1'b0;
        end
    end

    assign seq_pc = pc_i + 32'd4;

    assign wb_data_o    = sum;
    assign next_pc_o    = exe.is_jump ? jump_target : seq_pc;
    assign store_addr_o = sum;
    assign store_data_o = rdata2_i;

endmodule

`default_nettype wire

//--- source/regfile.sv
`timescale 1ns/1ns
`default_nettype none

module regfile
    import core_types_pkg::*;
(
    input  wire             clk_i,
    input  wire             rst_i,
    input  wire reg_addr_t  raddr1_i,
    input  wire reg_addr_t  raddr2_i,
    output word_t           rdata1_o,
    output word_t           rdata2_o,
    input  wire             we_i,
    input  wire reg_addr_t  waddr_i,
    input  wire word_t      wdata_i
);

    word_t regs [NREGS];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 0; i < NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && waddr_i != ZERO_REG) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // x0 reads zero whatever was written.
    assign rdata1_o = (raddr1_i == ZERO_REG) ? '0 : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == ZERO_REG) ? '0 : regs[raddr2_i];

endmodule

`default_nettype wire

//--- source/decode_unit.sv
`timescale 1ns/1ns
`default_nettype none

module decode_unit
    import core_types_pkg::*;
    import rv_isa_pkg::*;
(
    input  wire inst_t  inst_i,
    input  wire addr_t  pc_i,
    input  wire word_t  rdata1_i,
    input  wire word_t  rdata2_i,
    output reg_addr_t   raddr1_o,
    output reg_addr_t   raddr2_o,
    idu_exu_if.dec      dec
);

    opcode_t   opcode;
    funct3_t   funct3;
    reg_addr_t rd;
    reg_addr_t rs1;
    reg_addr_t rs2;

    assign opcode = get_opcode(inst_i);
    assign funct3 = get_funct3(inst_i);
    assign rd     = get_rd(inst_i);
    assign rs1    = get_rs1(inst_i);
    assign rs2    = get_rs2(inst_i);

    always_comb begin
        dec.inst      = inst_i;
        dec.reg_wen   = 1'b0;
        dec.waddr     = ZERO_REG;
        dec.is_store  = 1'b0;
        dec.is_jump   = 1'b0;
        dec.is_ebreak = (inst_i == INST_EBREAK);
        raddr1_o      = ZERO_REG;
        raddr2_o      = ZERO_REG;
        dec.op1       = '0;
        dec.op2       = '0;
        dec.op1_jump  = '0;
        dec.op2_jump  = '0;

        case (opcode)
            OPC_OP_IMM: begin
                if (funct3 == F3_ADDI) begin
                    dec.reg_wen = 1'b1;
                    dec.waddr   = rd;
                    raddr1_o    = rs1;
                    dec.op1     = rdata1_i;
                    dec.op2     = imm_i(inst_i);
                end
            end

            OPC_STORE: begin
                if (funct3 == F3_SW) begin
                    dec.is_store = 1'b1;
                    raddr1_o     = rs1;
                    raddr2_o     = rs2;
                    dec.op1      = rdata1_i;
                    dec.op2      = imm_s(inst_i);
                end
            end

            OPC_LUI: begin
                dec.reg_wen = 1'b1;
                dec.waddr   = rd;
                dec.op1     = imm_u(inst_i);
            end

            OPC_AUIPC: begin
                dec.reg_wen = 1'b1;
                dec.waddr   = rd;
                dec.op1     = pc_i;
                dec.op2     = imm_u(inst_i);
            end

            OPC_JAL: begin
                dec.reg_wen  = 1'b1;
                dec.waddr    = rd;
                dec.is_jump  = 1'b1;
                dec.op1      = pc_i;
                dec.op2      = 32'd4;
                dec.op1_jump = pc_i;
                dec.op2_jump = imm_j(inst_i);
            end

            OPC_JALR: begin
                dec.reg_wen  = 1'b1;
                dec.waddr    = rd;
                dec.is_jump  = 1'b1;
                raddr1_o     = rs1;
                dec.op1      = pc_i;
                dec.op2      = 32'd4;
                dec.op1_jump = rdata1_i;
                dec.op2_jump = imm_i(inst_i);
            end

            // everything else, ebreak included, retires as a nop.
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- source/fetch_unit.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_unit
    import core_types_pkg::*;
    import rv_isa_pkg::*;
(
    input  wire         clk_i,
    input  wire         rst_i,
    output logic        imem_req_o,
    output addr_t       imem_addr_o,
    input  wire inst_t  imem_rdata_i,
    input  wire         imem_ack_i,
    output logic        dmem_req_o,
    input  wire         dmem_ack_i,
    input  wire         is_store_i,
    input  wire         is_ebreak_i,
    input  wire addr_t  next_pc_i,
    output inst_t       inst_o,
    output addr_t       pc_o,
    output logic        commit_o,
    output logic        halted_o
);

    ctrl_state_t state_q;
    ctrl_state_t state_d;
    addr_t       pc_q;
    inst_t       ir_q;
    logic        imem_req_q;
    logic        dmem_req_q;

    always_comb begin
        state_d  = state_q;
        commit_o = 1'b0;
        case (state_q)
            S_FETCH_REQ: begin
                if (imem_req_q && imem_ack_i) begin
                    state_d = S_FETCH_REL;
                end
            end
            S_FETCH_REL: begin
                if (!imem_ack_i) begin
                    state_d = S_EXEC;
                end
            end
            S_EXEC: begin
                if (is_store_i) begin
                    state_d = S_STORE_REQ;
                end else begin
                    commit_o = 1'b1;
                    state_d  = is_ebreak_i ? S_HALT : S_FETCH_REQ;
                end
            end
            S_STORE_REQ: begin
                if (dmem_req_q && dmem_ack_i) begin
                    state_d = S_STORE_REL;
                end
            end
            S_STORE_REL: begin
                // the store retires once the memory has released ack.
                if (!dmem_ack_i) begin
                    commit_o = 1'b1;
                    state_d  = S_FETCH_REQ;
                end
            end
            S_HALT: ;
            default: state_d = S_FETCH_REQ;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q    <= S_FETCH_REQ;
            pc_q       <= RESET_PC;
            imem_req_q <= 1'b0;
            dmem_req_q <= 1'b0;
        end else begin
            state_q    <= state_d;
            imem_req_q <= (state_d == S_FETCH_REQ);
            dmem_req_q <= (state_d == S_STORE_REQ);
            if (commit_o) begin
                pc_q <= next_pc_i;
            end
        end
    end

    // decode sees a harmless word until the first fetch lands.
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ir_q <= INST_NOP_WORD;
        end else if (state_q == S_FETCH_REQ && imem_req_q && imem_ack_i) begin
            ir_q <= imem_rdata_i;
        end
    end

    assign imem_req_o  = imem_req_q;
    assign imem_addr_o = pc_q;
    assign dmem_req_o  = dmem_req_q;
    assign inst_o      = ir_q;
    assign pc_o        = pc_q;
    assign halted_o    = (state_q == S_HALT);

endmodule

`default_nettype wire

//--- source/idu_exu_if.sv
`timescale 1ns/1ns
`default_nettype none

interface idu_exu_if
    import core_types_pkg::*;
();

    word_t     op1;
    word_t     op2;
    word_t     op1_jump;
    word_t     op2_jump;
    logic      reg_wen;
    reg_addr_t waddr;
    logic      is_store;
    logic      is_jump;
    logic      is_ebreak;
    inst_t     inst;

    modport dec (
        output op1, op2, op1_jump, op2_jump,
        output reg_wen, waddr,
        output is_store, is_jump, is_ebreak,
        output inst
    );

    modport exe (
        input op1, op2, op1_jump, op2_jump,
        input is_jump, inst
    );

endinterface

`default_nettype wire

//--- source/core_types_pkg.sv
`default_nettype none

package core_types_pkg;

    localparam int XLEN   = 32;
    localparam int ILEN   = 32;
    localparam int REG_AW = 5;
    localparam int NREGS  = 1 << REG_AW;

    typedef logic [XLEN-1:0]   word_t;
    typedef logic [ILEN-1:0]   inst_t;
    typedef logic [XLEN-1:0]   addr_t;
    typedef logic [REG_AW-1:0] reg_addr_t;

    localparam reg_addr_t ZERO_REG = '0;
    localparam addr_t     RESET_PC = 32'h0000_0000;

    // one instruction in flight, both memory ports share this sequence.
    typedef enum logic [2:0] {
        S_FETCH_REQ,
        S_FETCH_REL,
        S_EXEC,
        S_STORE_REQ,
        S_STORE_REL,
        S_HALT
    } ctrl_state_t;

endpackage

`default_nettype wire

//--- source/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

    typedef logic [6:0] opcode_t;
    typedef logic [2:0] funct3_t;

    // major opcodes of the supported subset.
    localparam opcode_t OPC_OP_IMM = 7'b001_0011;
    localparam opcode_t OPC_STORE  = 7'b010_0011;
    localparam opcode_t OPC_LUI    = 7'b011_0111;
    localparam opcode_t OPC_AUIPC  = 7'b001_0111;
    localparam opcode_t OPC_JAL    = 7'b110_1111;
    localparam opcode_t OPC_JALR   = 7'b110_0111;

    localparam funct3_t F3_ADDI = 3'b000;
    localparam funct3_t F3_SW   = 3'b010;

    localparam logic [31:0] INST_EBREAK   = 32'h0010_0073;
    // addi x0, x0, 0.
    localparam logic [31:0] INST_NOP_WORD = 32'h0000_0013;

    function automatic opcode_t get_opcode(input logic [31:0] inst);
        return inst[6:0];
    endfunction

    function automatic funct3_t get_funct3(input logic [31:0] inst);
        return inst[14:12];
    endfunction

    function automatic logic [4:0] get_rd(input logic [31:0] inst);
        return inst[11:7];
    endfunction

    function automatic logic [4:0] get_rs1(input logic [31:0] inst);
        return inst[19:15];
    endfunction

    function automatic logic [4:0] get_rs2(input logic [31:0] inst);
        return inst[24:20];
    endfunction

    function automatic logic [31:0] imm_i(input logic [31:0] inst);
        return {{20{inst[31]}}, inst[31:20]};
    endfunction

    function automatic logic [31:0] imm_s(input logic [31:0] inst);
        return {{20{inst[31]}}, inst[31:25], inst[11:7]};
    endfunction

    function automatic logic [31:0] imm_u(input logic [31:0] inst);
        return {inst[31:12], 12'b0};
    endfunction

    // j-immediate bits are scattered, bit 0 is implied zero.
    function automatic logic [31:0] imm_j(input logic [31:0] inst);
        return {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
    endfunction

endpackage

`default_nettype wire
